// File: verilog/rvIsaPkg.sv
package rvIsaPkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011
    } opcodeT;

    // branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // load funct3
    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;

    // store funct3
    localparam logic [2:0] f3Sb = 3'b000;
    localparam logic [2:0] f3Sh = 3'b001;
    localparam logic [2:0] f3Sw = 3'b010;

    // register and immediate ALU funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // instruction field positions
    localparam int opcodeLsb    = 0;
    localparam int opcodeMsb    = 6;
    localparam int rdLsb        = 7;
    localparam int rdMsb        = 11;
    localparam int funct3Lsb    = 12;
    localparam int funct3Msb    = 14;
    localparam int rs1Lsb       = 15;
    localparam int rs1Msb       = 19;
    localparam int rs2Lsb       = 20;
    localparam int rs2Msb       = 24;
    // selects sub and sra
    localparam int funct7AltBit = 30;

endpackage

// File: verilog/cpuCtrlPkg.sv
package cpuCtrlPkg;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpT;

    // width of the loaded value before extension
    typedef enum logic [1:0] {
        loadByte = 2'd0,
        loadHalf = 2'd1,
        loadWord = 2'd2
    } loadSelT;

    // store width, picks the base byte mask
    typedef enum logic [1:0] {
        maskByte = 2'd0,
        maskHalf = 2'd1,
        maskWord = 2'd2
    } maskSelT;

    // writeback source when not loading from memory
    typedef enum logic [1:0] {
        regAluRes = 2'd0,
        regPcImm  = 2'd1,
        regImm    = 2'd2,
        regPc4    = 2'd3
    } regDataSelT;

endpackage

// File: verilog/controller.sv
`timescale 1ns/1ps

module controller import rvIsaPkg::*, cpuCtrlPkg::*; (
    input  logic [31:0] instruction,
    input  logic        aluZero,
    input  logic        aluLess,
    output aluOpT       aluCtrl,
    output logic        aluImm,
    output logic        aluToPc,
    output logic        branch,
    output loadSelT     loadSel,
    output maskSelT     maskSel,
    output logic        memToReg,
    output logic        memWr,
    output regDataSelT  regDataSel,
    output logic        regWr,
    output logic        uext,
    output logic        except
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       altBit;
    aluOpT      arithOp;
    aluOpT      cmpOp;
    logic       taken;

    assign opcode = opcodeT'(instruction[opcodeMsb:opcodeLsb]);
    assign funct3 = instruction[funct3Msb:funct3Lsb];
    assign altBit = instruction[funct7AltBit];

    // op-imm and op share funct3, only op has sub
    always_comb begin
        case (funct3)
            f3AddSub: arithOp = (opcode == opReg && altBit) ? aluSub : aluAdd;
            f3Sll:    arithOp = aluSll;
            f3Slt:    arithOp = aluSlt;
            f3Sltu:   arithOp = aluSltu;
            f3Xor:    arithOp = aluXor;
            f3SrlSra: arithOp = altBit ? aluSra : aluSrl;
            f3Or:     arithOp = aluOr;
            default:  arithOp = aluAnd;
        endcase
    end

    // compare op for branches
    always_comb begin
        case (funct3)
            f3Beq, f3Bne: cmpOp = aluSub;
            f3Blt, f3Bge: cmpOp = aluSlt;
            default:      cmpOp = aluSltu;
        endcase
    end

    always_comb begin
        case (funct3)
            f3Beq:         taken = aluZero;
            f3Bne:         taken = !aluZero;
            f3Blt, f3Bltu: taken = aluLess;
            f3Bge, f3Bgeu: taken = !aluLess;
            default:       taken = 1'b0;
        endcase
    end

    always_comb begin
        aluCtrl    = aluAdd;
        aluImm     = 1'b0;
        aluToPc    = 1'b0;
        branch     = 1'b0;
        loadSel    = loadWord;
        maskSel    = maskWord;
        memToReg   = 1'b0;
        memWr      = 1'b0;
        regDataSel = regAluRes;
        regWr      = 1'b0;
        uext       = 1'b0;
        except     = 1'b0;
        case (opcode)
            opLui: begin
                regWr      = 1'b1;
                regDataSel = regImm;
            end
            opAuipc: begin
                regWr      = 1'b1;
                regDataSel = regPcImm;
            end
            opJal: begin
                branch     = 1'b1;
                regWr      = 1'b1;
                regDataSel = regPc4;
            end
            opJalr: begin
                // target is rs1 + imm from the ALU
                aluImm     = 1'b1;
                aluToPc    = 1'b1;
                branch     = 1'b1;
                regWr      = 1'b1;
                regDataSel = regPc4;
            end
            opBranch: begin
                aluCtrl = cmpOp;
                branch  = taken;
            end
            opLoad: begin
                aluImm   = 1'b1;
                memToReg = 1'b1;
                regWr    = 1'b1;
                uext     = (funct3 == f3Lbu) || (funct3 == f3Lhu);
                case (funct3)
                    f3Lb, f3Lbu: loadSel = loadByte;
                    f3Lh, f3Lhu: loadSel = loadHalf;
                    f3Lw:        loadSel = loadWord;
                    default:     loadSel = loadWord;
                endcase
            end
            opStore: begin
                aluImm = 1'b1;
                memWr  = 1'b1;
                case (funct3)
                    f3Sb:    maskSel = maskByte;
                    f3Sh:    maskSel = maskHalf;
                    f3Sw:    maskSel = maskWord;
                    default: maskSel = maskWord;
                endcase
            end
            opImm: begin
                aluImm  = 1'b1;
                aluCtrl = arithOp;
                regWr   = 1'b1;
            end
            opReg: begin
                aluCtrl = arithOp;
                regWr   = 1'b1;
            end
            default: except = 1'b1;
        endcase
    end

endmodule

// File: verilog/immDecoder.sv
`timescale 1ns/1ps

module immDecoder import rvIsaPkg::*; (
    input  logic [31:0] instruction,
    output logic [31:0] imm
);

    opcodeT     opcode;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    assign opcode = opcodeT'(instruction[opcodeMsb:opcodeLsb]);

    // sign always comes from bit 31
    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        case (opcode)
            opImm, opLoad, opJalr: imm = immI;
            opStore:               imm = immS;
            opBranch:              imm = immB;
            opLui, opAuipc:        imm = immU;
            opJal:                 imm = immJ;
            // register ops have no immediate
            default:               imm = 32'b0;
        endcase
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import cpuCtrlPkg::*; #(
    parameter int xlen = 32
) (
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    input  aluOpT           ctrl,
    output logic [xlen-1:0] res,
    output logic            zero,
    output logic            less
);

    localparam int shW = $clog2(xlen);

    logic [shW-1:0] shamt;
    logic           lessSigned;
    logic           lessUnsigned;

    assign shamt        = op2[shW-1:0];
    assign lessSigned   = $signed(op1) < $signed(op2);
    assign lessUnsigned = op1 < op2;

    // branches read this flag too, so it follows the op
    assign less = (ctrl == aluSltu) ? lessUnsigned : lessSigned;

    always_comb begin
        case (ctrl)
            aluAdd:  res = op1 + op2;
            aluSub:  res = op1 - op2;
            aluSll:  res = op1 << shamt;
            aluSlt:  res = {{(xlen-1){1'b0}}, lessSigned};
            aluSltu: res = {{(xlen-1){1'b0}}, lessUnsigned};
            aluXor:  res = op1 ^ op2;
            aluSrl:  res = op1 >> shamt;
            aluSra:  res = $signed(op1) >>> shamt;
            aluOr:   res = op1 | op2;
            aluAnd:  res = op1 & op2;
            default: res = '0;
        endcase
    end

    assign zero = (res == '0);

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic [4:0]      readAddr1,
    input  logic [4:0]      readAddr2,
    input  logic [4:0]      writeAddr,
    input  logic [xlen-1:0] writeData,
    input  logic            writeEn,
    output logic [xlen-1:0] readData1,
    output logic [xlen-1:0] readData2
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

    always_ff @(posedge clk) begin
        if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// File: verilog/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit import cpuCtrlPkg::*; (
    input  logic [1:0]  addrLow,
    input  loadSelT     loadSel,
    input  maskSelT     maskSel,
    input  logic        uext,
    input  logic [31:0] memReadData,
    input  logic [31:0] storeData,
    output logic [31:0] loadData,
    output logic [3:0]  wrMask,
    output logic [31:0] memWriteData
);

    logic [3:0]  baseMask;
    logic [4:0]  storeShift;
    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    always_comb begin
        case (maskSel)
            maskByte: begin
                baseMask   = 4'b0001;
                storeShift = {addrLow, 3'b0};
            end
            maskHalf: begin
                baseMask   = 4'b0011;
                storeShift = {addrLow[1], 4'b0};
            end
            default: begin
                baseMask   = 4'b1111;
                storeShift = 5'd0;
            end
        endcase
    end

    assign wrMask       = baseMask << addrLow;
    assign memWriteData = storeData << storeShift;

    // pick the addressed lane
    assign byteLane = memReadData[{addrLow, 3'b0} +: 8];
    assign halfLane = addrLow[1] ? memReadData[31:16] : memReadData[15:0];

    always_comb begin
        case (loadSel)
            loadByte: loadData = {{24{~uext & byteLane[7]}}, byteLane};
            loadHalf: loadData = {{16{~uext & halfLane[15]}}, halfLane};
            default:  loadData = memReadData;
        endcase
    end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu import rvIsaPkg::*, cpuCtrlPkg::*; #(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    input  logic [31:0] memReadData,
    output logic        memWr,
    output logic        except,
    output logic [3:0]  wrMask,
    output logic [31:0] pc,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData
);

    localparam int xlen = 32;

    aluOpT      aluCtrl;
    loadSelT    loadSel;
    maskSelT    maskSel;
    regDataSelT regDataSel;
    logic       aluImm, aluToPc, branch, memToReg, memWrCtrl, regWr, uext;
    logic       aluZero, aluLess;
    logic [31:0] imm, rs1Data, rs2Data, aluOp2, aluRes, loadData;
    logic [31:0] pc4, pcImm, branchTarget, nextPc, regData, regRes;

    controller ctrl0 (
        .instruction(instruction), .aluZero(aluZero), .aluLess(aluLess),
        .aluCtrl(aluCtrl), .aluImm(aluImm), .aluToPc(aluToPc), .branch(branch),
        .loadSel(loadSel), .maskSel(maskSel), .memToReg(memToReg), .memWr(memWrCtrl),
        .regDataSel(regDataSel), .regWr(regWr), .uext(uext), .except(except)
    );

    immDecoder imm0 (.instruction(instruction), .imm(imm));

    registerFile #(.xlen(xlen)) regs0 (
        .clk(clk), .readAddr1(instruction[rs1Msb:rs1Lsb]),
        .readAddr2(instruction[rs2Msb:rs2Lsb]), .writeAddr(instruction[rdMsb:rdLsb]),
        .writeData(regRes), .writeEn(regWr & ~reset),
        .readData1(rs1Data), .readData2(rs2Data)
    );

    alu #(.xlen(xlen)) alu0 (
        .op1(rs1Data), .op2(aluOp2), .ctrl(aluCtrl),
        .res(aluRes), .zero(aluZero), .less(aluLess)
    );

    loadStoreUnit lsu0 (
        .addrLow(aluRes[1:0]), .loadSel(loadSel), .maskSel(maskSel), .uext(uext),
        .memReadData(memReadData), .storeData(rs2Data), .loadData(loadData),
        .wrMask(wrMask), .memWriteData(memWriteData)
    );

    assign aluOp2  = aluImm ? imm : rs2Data;
    assign memAddr = aluRes;
    assign memWr   = memWrCtrl & ~reset;

    assign pc4   = pc + 32'd4;
    assign pcImm = pc + imm;
    // jalr clears bit 0 of the target
    assign branchTarget = aluToPc ? {aluRes[31:1], 1'b0} : pcImm;
    assign nextPc       = branch ? branchTarget : pc4;

    always_comb begin
        case (regDataSel)
            regAluRes: regData = aluRes;
            regPcImm:  regData = pcImm;
            regImm:    regData = imm;
            default:   regData = pc4;
        endcase
    end

    assign regRes = memToReg ? loadData : regData;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: bench/cpuProps.sv
`timescale 1ns/1ps

module cpuProps (
    input logic        clk,
    input logic        reset,
    input logic        memWr,
    input logic        except,
    input logic [3:0]  wrMask,
    input logic [31:0] pc
);

    // stores are gated off while reset is held
    noWriteInReset: assert property (@(posedge clk) reset |-> !memWr)
        else $error("memWr high during reset");

    maskOnWrite: assert property (@(posedge clk) disable iff (reset) memWr |-> wrMask != 4'b0)
        else $error("store with an empty byte mask");

    // unknown opcodes never write memory
    noWriteOnExcept: assert property (@(posedge clk) disable iff (reset) !(except && memWr))
        else $error("except and memWr high together");

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import rvIsaPkg::*; ();

    localparam logic [31:0] resetVector = 32'h0000_1000;
    localparam int numSteps = 2000;
    // lui plus addi for each of x1..x31
    localparam int initSteps = 62;
    localparam logic [31:0] nop = 32'h0000_0013;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] memReadData;
    logic        memWr;
    logic        except;
    logic [3:0]  wrMask;
    logic [31:0] pc;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;

    // architectural model and the expected outputs of the current instruction
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    logic [31:0] expPc;
    logic [31:0] expAddr;
    logic [31:0] expData;
    logic [3:0]  expMask;
    logic        expWr;
    logic        expExc;
    logic        expLoad;
    logic        armed;
    logic        observe;
    logic [4:0]  observeRd;
    string       testName;
    int          issued;
    int          checked;

    cpu #(.resetVector(resetVector)) dut0 (
        .clk(clk), .reset(reset), .instruction(instruction), .memReadData(memReadData),
        .memWr(memWr), .except(except), .wrMask(wrMask), .pc(pc), .memAddr(memAddr),
        .memWriteData(memWriteData)
    );

    bind cpu cpuProps props0 (
        .clk(clk), .reset(reset), .memWr(memWr), .except(except), .wrMask(wrMask), .pc(pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // data memory words hashed from the full address
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        logic [31:0] wordAddr;
        wordAddr = {addr[31:2], 2'b00};
        return (wordAddr * 32'h9E37_79B1) ^ {wordAddr[15:0], wordAddr[31:16]};
    endfunction

    assign memReadData = reset ? 32'h0 : memWord(memAddr);

    task automatic checkValue(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", testName, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] laneBits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic sub,
            input logic sra, input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            f3AddSub: return sub ? a - b : a + b;
            f3Sll:    return a << b[4:0];
            f3Slt:    return {31'b0, $signed(a) < $signed(b)};
            f3Sltu:   return {31'b0, a < b};
            f3Xor:    return a ^ b;
            f3SrlSra: begin
                if (sra) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            f3Or:     return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            f3Beq:   return a == b;
            f3Bne:   return a != b;
            f3Blt:   return $signed(a) < $signed(b);
            f3Bge:   return $signed(a) >= $signed(b);
            f3Bltu:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] loadValue(input logic [2:0] f3, input logic [1:0] off,
            input logic [31:0] word);
        logic [7:0]  b8;
        logic [15:0] h16;
        b8  = 8'(word >> (8 * off));
        h16 = 16'(word >> (8 * off));
        case (f3)
            f3Lb:    return {{24{b8[7]}}, b8};
            f3Lbu:   return {24'b0, b8};
            f3Lh:    return {{16{h16[15]}}, h16};
            f3Lhu:   return {16'b0, h16};
            default: return word;
        endcase
    endfunction

    // one RV32I step on the model that also sets the exp* values
    function automatic void isaStep(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] next;
        logic [4:0]  rd;
        logic        wrRd;
        rd      = ins[11:7];
        a       = modelRegs[ins[19:15]];
        b       = modelRegs[ins[24:20]];
        immI    = {{20{ins[31]}}, ins[31:20]};
        immS    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU    = {ins[31:12], 12'b0};
        immJ    = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        expPc   = modelPc;
        expWr   = 1'b0;
        expExc  = 1'b0;
        expLoad = 1'b0;
        expAddr = '0;
        expMask = '0;
        expData = '0;
        next    = modelPc + 32'd4;
        wrRd    = 1'b1;
        res     = '0;
        case (ins[6:0])
            opLui:   res = immU;
            opAuipc: res = modelPc + immU;
            opJal: begin
                res  = modelPc + 32'd4;
                next = modelPc + immJ;
            end
            opJalr: begin
                res  = modelPc + 32'd4;
                next = (a + immI) & ~32'd1;
            end
            opBranch: begin
                wrRd = 1'b0;
                if (branchTaken(ins[14:12], a, b)) begin
                    next = modelPc + immB;
                end
            end
            opLoad: begin
                expLoad = 1'b1;
                expAddr = a + immI;
                res     = loadValue(ins[14:12], expAddr[1:0], memWord(expAddr));
            end
            opStore: begin
                wrRd    = 1'b0;
                expWr   = 1'b1;
                expAddr = a + immS;
                expData = b << (8 * expAddr[1:0]);
                case (ins[14:12])
                    f3Sb:    expMask = 4'b0001 << expAddr[1:0];
                    f3Sh:    expMask = 4'b0011 << expAddr[1:0];
                    default: expMask = 4'b1111 << expAddr[1:0];
                endcase
            end
            opImm: res = aluResult(ins[14:12], 1'b0, ins[30], a, immI);
            opReg: res = aluResult(ins[14:12], ins[30], ins[30], a, b);
            default: begin
                wrRd   = 1'b0;
                expExc = 1'b1;
            end
        endcase
        if (wrRd && rd != 5'd0) begin
            modelRegs[rd] = res;
        end
        modelPc = next;
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // offset that puts base + imm on the wanted low address bits
    function automatic logic [11:0] offsetTo(input logic [31:0] base, input logic [1:0] low);
        logic [11:0] imm;
        imm      = 12'($urandom);
        imm[1:0] = low - base[1:0];
        return imm;
    endfunction

    // legal random instruction that reads the model to keep pc and accesses aligned
    function automatic logic [31:0] nextInstr(input int step);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [1:0]  low;
        logic [31:0] ins;
        logic        alt;
        int          kind;
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        f3  = 3'($urandom);
        low = 2'($urandom);
        alt = (f3 == f3AddSub || f3 == f3SrlSra) ? 1'($urandom) : 1'b0;
        if (step < initSteps) begin
            testName = "init";
            rd       = 5'(step / 2 + 1);
            if (step % 2 == 0) begin
                return {20'($urandom), rd, opLui};
            end
            return encI(12'($urandom), rd, f3AddSub, rd, opImm);
        end
        // expose the last result through a store
        if (observe) begin
            observe = 1'b0;
            return encS(offsetTo(modelRegs[rs1], 2'b00), observeRd, rs1, f3Sw);
        end
        observe   = 1'b1;
        observeRd = rd;
        kind      = $urandom_range(8);
        case (kind)
            0: begin
                testName = "alu reg";
                ins      = encI({1'b0, alt, 5'b0, rs2}, rs1, f3, rd, opReg);
            end
            1: begin
                testName = "alu imm";
                ins      = encI(12'($urandom), rs1, f3, rd, opImm);
                if (f3 == f3Sll || f3 == f3SrlSra) begin
                    ins[31:25] = {1'b0, alt, 5'b0};
                end
            end
            2: begin
                testName = "load";
                if (f3 == 3'b011 || f3[2:1] == 2'b11) begin
                    f3 = f3Lw;
                end
                if (f3 == f3Lw) begin
                    low = 2'b00;
                end else if (f3[0]) begin
                    low[0] = 1'b0;
                end
                ins = encI(offsetTo(modelRegs[rs1], low), rs1, f3, rd, opLoad);
            end
            3: begin
                testName = "store";
                observe  = 1'b0;
                f3       = 3'($urandom_range(2));
                if (f3 == f3Sw) begin
                    low = 2'b00;
                end else if (f3 == f3Sh) begin
                    low[0] = 1'b0;
                end
                ins = encS(offsetTo(modelRegs[rs1], low), rs2, rs1, f3);
            end
            4: begin
                testName = "branch";
                observe  = 1'b0;
                // equal operands now and then so that beq and bge take
                if ($urandom_range(3) == 0) begin
                    rs2 = rs1;
                end
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    f3 = f3Beq;
                end
                ins = encB(13'($urandom) & 13'h1ffc, rs2, rs1, f3);
            end
            5: begin
                testName = "jal";
                ins      = encJ(21'($urandom) & 21'h1ffffc, rd);
            end
            6: begin
                testName = "jalr";
                ins      = encI(offsetTo(modelRegs[rs1], 2'b00), rs1, 3'b000, rd, opJalr);
            end
            7: begin
                testName = "auipc";
                ins      = {20'($urandom), rd, opAuipc};
            end
            default: begin
                testName = "illegal";
                ins      = {25'($urandom), (alt ? 7'b0001111 : 7'b1110011)};
            end
        endcase
        return ins;
    endfunction

    // compare at the rising edge before pc and registers update
    always @(posedge clk) begin
        if (reset) begin
            checkValue("memWr in reset", 1'b0, memWr);
        end else if (armed) begin
            checkValue("pc", expPc, pc);
            checkValue("memWr", expWr, memWr);
            checkValue("except", expExc, except);
            if (expWr || expLoad) begin
                checkValue("memAddr", expAddr, memAddr);
            end
            if (expWr) begin
                checkValue("wrMask", expMask, wrMask);
                checkValue("memWriteData", expData & laneBits(expMask),
                           memWriteData & laneBits(expMask));
            end
            checked++;
        end
    end

    initial begin
        int waitCycles;
        void'($urandom(32'h6952));
        reset       = 1'b1;
        instruction = nop;
        armed       = 1'b0;
        observe     = 1'b0;
        observeRd   = '0;
        issued      = 0;
        checked     = 0;
        testName    = "reset";
        modelPc     = resetVector;
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        repeat (2) @(posedge clk);
        // a store held in reset must not reach the memory
        @(negedge clk);
        instruction = encS(12'h0, 5'd0, 5'd0, f3Sw);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkValue("pc", resetVector, pc);
        for (int step = 0; step < numSteps; step++) begin
            instruction = nextInstr(step);
            isaStep(instruction);
            armed = 1'b1;
            issued++;
            @(negedge clk);
        end
        waitCycles = 0;
        while (checked != issued) begin
            if (waitCycles == 10) begin
                $display("compare process did not check the last instructions in time");
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end else begin
                waitCycles++;
                @(negedge clk);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: list.f
verilog/rvIsaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/controller.sv
verilog/immDecoder.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/loadStoreUnit.sv
verilog/cpu.sv
bench/cpuProps.sv
bench/cpuTb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - target: any(rtl, test)
    files:
      - verilog/rvIsaPkg.sv
      - verilog/cpuCtrlPkg.sv
      - verilog/controller.sv
      - verilog/immDecoder.sv
      - verilog/alu.sv
      - verilog/registerFile.sv
      - verilog/loadStoreUnit.sv
      - verilog/cpu.sv
  - target: test
    files:
      - bench/cpuProps.sv
      - bench/cpuTb.sv
